//--- verif/fpAdderVectors.txt
# Columns: operand A, operand B, op (0 add, 1 subtract), expected result, expected flags
# All values hex; flags = {overflow, zero}
3F800000 3F800000 0 40000000 0
3F800000 40000000 0 40400000 0
3FC00000 3FC00000 0 40400000 0
41200000 41A00000 0 41F00000 0
3DCCCCCD 3E4CCCCD 0 3E99999A 0
3F800000 34000000 0 3F800001 0
3F800000 33800000 0 3F800000 0
3F800001 33800000 0 3F800002 0
3F800000 33000000 0 3F800000 0
3F800000 32800000 0 3F800000 0
3F800000 30800000 0 3F800000 0
4B800000 3F800000 0 4B800000 0
4B800000 40400000 0 4B800002 0
4B800000 3FC00000 0 4B800001 0
4B800000 3F400000 0 4B800000 0
4B7FFFFF 3F000000 0 4B800000 0
4B7FFFFF 3F000001 0 4B800000 0
40400000 3F800000 1 40000000 0
3F800000 40400000 1 C0000000 0
40A00000 C0400000 0 40000000 0
C0A00000 40400000 1 C1000000 0
C7000000 3F800000 0 C6FFFE00 0
3F800000 3F7FFFFF 1 33800000 0
3F800001 3F800000 1 34000000 0
3F800000 33800000 1 3F7FFFFF 0
3F800000 33000000 1 3F800000 0
CB800000 30800000 0 CB800000 0
40490FDB 40490FDB 1 00000000 1
C0490FDB 40490FDB 0 00000000 1
7F7FFFFF 7F7FFFFF 0 7F800000 2
FF7FFFFF FF7FFFFF 0 FF800000 2
7F7FFFFF 73000000 0 7F800000 2
FF7FFFFF 7F7FFFFF 1 FF800000 2
00800001 00800000 1 00000000 1
80800001 80800000 1 80000000 1
00FFFFFF 00800000 1 00000000 1
01000000 00800000 1 00800000 0

//--- compile.f
source/fpAddPkg.sv
source/alignment.sv
source/mantissaAdder.sv
source/normalizer.sv
source/rounder.sv
source/addControl.sv
source/fpAdder.sv
verif/fpAdderTb.sv

//--- Makefile
# Verilator build and run of the binary32 adder testbench
TOP = fpAdderTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f compile.f

# The run passes only if the log holds the pass message
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/fpAdderTb.sv
// Run from the project root so the vector file opens; flags column is {overflow, zero}
`timescale 1ns/1ps

module fpAdderTb;

    localparam int ClkPeriod   = 20;                        // ns
    localparam int ResetCycles = 4;
    localparam int DoneLatency = 4;                         // Edges from the start edge to done
    localparam int MaxWait     = 20;                        // Cycles before done counts as missing

    logic        clk;
    logic        rstN;
    logic        start;
    logic        op;                                        // 0 add, 1 subtract
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        overflow;
    logic        zero;
    logic        done;

    logic [31:0] vecA[$];                                   // Operand A per test
    logic [31:0] vecB[$];                                   // Operand B per test
    logic [31:0] vecOp[$];                                  // Only bit 0 is used
    logic [31:0] vecResult[$];                              // Expected result word
    logic [31:0] vecFlags[$];                               // Expected {overflow, zero}
    logic        vectorsLoaded;                             // Releases the watchdog
    int          checkCount;
    int          errorCount;

    fpAdder i_fpAdder
    (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .op       (op),
        .a        (a),
        .b        (b),
        .result   (result),
        .overflow (overflow),
        .zero     (zero),
        .done     (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(ClkPeriod / 2) clk = ~clk;
    end

    // Per vector at most a 3-cycle gap plus about 7 cycles of operation
    initial
    begin
        int limit;
        wait (vectorsLoaded);
        limit = vecA.size() * 10 + ResetCycles + 20;         // Extra room for the busy-start test
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic checkValue
    (
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic loadVectors();
        int          fd;
        int          status;
        int          lineNo;
        string       line;
        logic [31:0] fA;
        logic [31:0] fB;
        logic [31:0] fOp;
        logic [31:0] fRes;
        logic [31:0] fFlags;
        fd = $fopen("verif/fpAdderVectors.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verif/fpAdderVectors.txt for reading");
            errorCount++;
        end
        else
        begin
            lineNo = 0;
            while (!$feof(fd))
            begin
                status = $fgets(line, fd);
                lineNo++;
                if (status == 0 || line.len() < 2 || line.getc(0) == "#")
                    continue;                               // Blank or column description
                status = $sscanf(line, "%h %h %h %h %h", fA, fB, fOp, fRes, fFlags);
                if (status != 5)
                begin
                    $display("Line %0d of the vector file could not be parsed", lineNo);
                    errorCount++;
                end
                else
                begin
                    vecA.push_back(fA);
                    vecB.push_back(fB);
                    vecOp.push_back(fOp);
                    vecResult.push_back(fRes);
                    vecFlags.push_back(fFlags);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runVector(input int idx, input logic pokeBusy);
        int    cycles;
        logic  gotDone;
        string tag;
        tag = $sformatf("vec%0d", idx);
        @(posedge clk);
        a <= vecA[idx];
        b <= vecB[idx];
        op <= vecOp[idx][0];
        start <= 1'b1;                                      // DUT samples it on the next edge
        cycles = 0;
        gotDone = 1'b0;
        while (!gotDone && cycles < MaxWait)
        begin
            @(posedge clk);
            if (pokeBusy && cycles == 1)
            begin
                a <= 32'h40490FDB;                          // Different operands that must not load
                b <= 32'h3F800000;
                op <= ~vecOp[idx][0];
                start <= 1'b1;                              // Seen in ADD and dropped
            end
            else
                start <= 1'b0;
            @(negedge clk);
            if (pokeBusy && cycles == 1)
                checkValue({tag, " busy"}, 32'd1, 32'(i_fpAdder.busy)); // Start lands mid-op
            if (done)
                gotDone = 1'b1;
            else
                cycles++;
        end
        if (!gotDone)
        begin
            $display("%s: done never arrived within %0d cycles of start", tag, MaxWait);
            errorCount++;
        end
        else
        begin
            checkValue({tag, " latency"}, DoneLatency, cycles);
            checkValue({tag, " result"}, vecResult[idx], result);
            checkValue({tag, " flags"}, vecFlags[idx], {30'b0, overflow, zero});
            @(negedge clk);
            checkValue({tag, " done width"}, 32'd0, 32'(done)); // Pulse lasts one cycle
            if (pokeBusy)
            begin
                repeat (6)
                begin
                    @(negedge clk);
                    checkValue({tag, " extra done"}, 32'd0, 32'(done));
                end
                checkValue({tag, " result held"}, vecResult[idx], result);
            end
        end
    endtask

    initial
    begin
        int unsigned gap;
        void'($urandom(32'h3180_bac6));                     // Fixed seed for the idle gaps
        checkCount = 0;
        errorCount = 0;
        vectorsLoaded = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        op = 1'b0;
        a = '0;
        b = '0;
        loadVectors();
        vectorsLoaded = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("reset done", 32'd0, 32'(done));
        checkValue("reset result", 32'd0, result);
        checkValue("reset flags", 32'd0, {30'b0, overflow, zero});
        if (vecA.size() == 0)
        begin
            $display("No test vectors were loaded, nothing was run");
            errorCount++;
        end
        for (int i = 0; i < vecA.size(); i++)
        begin
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
            runVector(i, i == 0);                           // First vector also gets a busy start
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- source/fpAdder.sv
// Binary32 add or subtract of normal operands; result valid with done, four edges after start
`timescale 1ns/1ps

module fpAdder
    import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        start,                              // Sampled only in IDLE
    input  logic        op,                                 // 0 add, 1 subtract
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        overflow,
    output logic        zero,
    output logic        done
);

    logic        alignEn;                                   // Stage enables from the FSM
    logic        addEn;
    logic        normEn;
    logic        roundEn;
    logic        busy;                                      // Probe for ignored starts
    alignedOps_t aligned;                                   // Stage 1 to stage 2
    sumResult_t  sum;                                       // Stage 2 to stage 3
    normResult_t norm;                                      // Stage 3 to stage 4

    addControl i_addControl
    (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .alignEn (alignEn),
        .addEn   (addEn),
        .normEn  (normEn),
        .roundEn (roundEn),
        .busy    (busy),
        .done    (done)
    );

    alignment i_alignment
    (
        .clk     (clk),
        .rstN    (rstN),
        .en      (alignEn),
        .op      (op),
        .opA     (fpOperand_t'(a)),                         // Raw word split into fields
        .opB     (fpOperand_t'(b)),
        .aligned (aligned)
    );

    mantissaAdder i_mantissaAdder
    (
        .clk     (clk),
        .rstN    (rstN),
        .en      (addEn),
        .aligned (aligned),
        .sum     (sum)
    );

    normalizer i_normalizer
    (
        .clk     (clk),
        .rstN    (rstN),
        .en      (normEn),
        .sum     (sum),
        .norm    (norm)
    );

    rounder i_rounder
    (
        .clk      (clk),
        .rstN     (rstN),
        .en       (roundEn),
        .norm     (norm),
        .result   (result),
        .overflow (overflow),
        .zero     (zero)
    );

endmodule

//--- source/addControl.sv
// One operation at a time; starts outside IDLE are dropped, done is a single-cycle pulse
`timescale 1ns/1ps

module addControl
    import fpAddPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic alignEn,
    output logic addEn,
    output logic normEn,
    output logic roundEn,
    output logic busy,
    output logic done
);

    addState_t state;                                       // Current sequencing step
    addState_t stateNext;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= IDLE;
            done <= 1'b0;
        end
        else
        begin
            state <= stateNext;
            done <= (state == ROUND);                       // Pulse as the FSM returns to IDLE
        end
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            IDLE:
            begin
                if (start)
                    stateNext = ALIGN;                      // Operands captured on this edge
            end
            ALIGN:
                stateNext = ADD;
            ADD:
                stateNext = NORM;
            NORM:
                stateNext = ROUND;
            ROUND:
                stateNext = IDLE;
            default:
                stateNext = IDLE;                           // Recover from an illegal encoding
        endcase
    end

    // Operand capture must happen on the start edge itself
    assign alignEn = (state == IDLE) && start;

    assign addEn   = (state == ADD);                        // Sum loads leaving ADD
    assign normEn  = (state == NORM);                       // Normalized value loads leaving NORM
    assign roundEn = (state == ROUND);                      // Result loads with the done edge
    assign busy    = (state != IDLE);                       // High while a start would be ignored

endmodule

//--- source/rounder.sv
// Nearest-even only; overflow saturates to signed infinity, exponent 0 or below flushes to zero
`timescale 1ns/1ps

module rounder
    import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        en,
    input  normResult_t norm,
    output logic [31:0] result,
    output logic        overflow,
    output logic        zero
);

    logic         roundUp;                                  // Increment the significand
    logic [24:0]  roundedSig;                               // Bit 24 is the rounding carry
    significand_t finalSig;                                 // Significand after renormalizing
    wideExp_t     expIn;                                    // Exponent from the normalizer
    wideExp_t     finalExp;                                 // Exponent after rounding carry
    fpOperand_t   packedWord;                               // Assembled result word
    logic         overflowNext;
    logic         zeroNext;

    always_comb
    begin
        roundUp = norm.guard & (norm.round | norm.sticky | norm.significand[0]); // Ties to even
        roundedSig = {1'b0, norm.significand} + 25'(roundUp);
        expIn = norm.exponent;

        if (roundedSig[24])
        begin
            finalSig = roundedSig[24:1];                    // 1.111 rolled over to 10.000
            finalExp = expIn + 10'sd1;
        end
        else
        begin
            finalSig = roundedSig[23:0];
            finalExp = expIn;
        end

        overflowNext = 1'b0;
        zeroNext = 1'b0;
        packedWord.sign = norm.sign;                        // Cancellation already carries +

        if (norm.isZero || (finalExp <= 10'sd0))
        begin
            packedWord.exponent = '0;                       // Signed zero
            packedWord.fraction = '0;
            zeroNext = 1'b1;
        end
        else if (finalExp >= 10'sd255)
        begin
            packedWord.exponent = 8'hFF;                    // Signed infinity
            packedWord.fraction = '0;
            overflowNext = 1'b1;
        end
        else
        begin
            packedWord.exponent = finalExp[7:0];
            packedWord.fraction = finalSig[22:0];           // Implicit one dropped
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            result <= '0;
            overflow <= 1'b0;
            zero <= 1'b0;
        end
        else if (en)
        begin
            result <= packedWord;                           // Held until the next round stage
            overflow <= overflowNext;
            zero <= zeroNext;
        end
    end

endmodule

//--- source/normalizer.sv
// Single right shift on carry or leading-zero left shift; exponent widened so underflow shows
`timescale 1ns/1ps

module normalizer
    import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        en,
    input  sumResult_t  sum,
    output normResult_t norm
);

    logic [4:0]  lzCount;                                   // Leading zeros below the carry bit
    logic        found;                                     // First one already seen
    extSig_t     normSig;                                   // Normalized significand with GRS
    wideExp_t    expIn;                                     // Incoming exponent, zero extended
    wideExp_t    expNext;                                   // Exponent after the shift
    normResult_t normNext;
    int          i;                                         // Bit scan index

    always_comb
    begin
        lzCount = '0;
        found = 1'b0;
        for (i = 26; i >= 0; i--)                           // Scan from the implicit one position
        begin
            if (!found && sum.magnitude[i])
            begin
                lzCount = 5'(26 - i);
                found = 1'b1;
            end
        end

        expIn = wideExp_t'({2'b00, sum.exponent});

        if (sum.magnitude[27])
        begin
            // Carry out of the add, drop one bit and keep it sticky
            normSig = {sum.magnitude[27:2], |sum.magnitude[1:0]};
            expNext = expIn + 10'sd1;
        end
        else
        begin
            normSig = sum.magnitude[26:0] << lzCount;       // Pull the leading one to bit 26
            expNext = expIn - wideExp_t'({5'b00000, lzCount});
        end

        normNext.sign = sum.sign;
        normNext.exponent = expNext;
        normNext.significand = normSig[26:3];
        normNext.guard = normSig[2];
        normNext.round = normSig[1];
        normNext.sticky = normSig[0];
        normNext.isZero = sum.exactZero;                    // Cancellation carried forward
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            norm <= '0;
        else if (en)
            norm <= normNext;
    end

endmodule

//--- source/mantissaAdder.sv
// Magnitude add or subtract of aligned 27-bit significands; exact cancellation forced positive
`timescale 1ns/1ps

module mantissaAdder
    import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        en,
    input  alignedOps_t aligned,
    output sumResult_t  sum
);

    logic [27:0] magA;                                      // A widened by a carry bit
    logic [27:0] magB;                                      // B widened by a carry bit
    logic        effSub;                                    // Signs differ after op applied
    logic        aGeB;                                      // A magnitude not below B
    sumResult_t  sumNext;

    always_comb
    begin
        magA = {1'b0, aligned.sigA};
        magB = {1'b0, aligned.sigB};
        effSub = aligned.signA ^ aligned.signB;
        aGeB = (aligned.sigA >= aligned.sigB);

        sumNext.exponent = aligned.exponent;                // Exponent fixed up by normalizer
        sumNext.exactZero = 1'b0;

        if (!effSub)
        begin
            sumNext.magnitude = magA + magB;                // Carry may land in bit 27
            sumNext.sign = aligned.signA;                   // Both signs agree
        end
        else if (aGeB)
        begin
            sumNext.magnitude = magA - magB;                // Larger minus smaller
            sumNext.sign = aligned.signA;
        end
        else
        begin
            sumNext.magnitude = magB - magA;
            sumNext.sign = aligned.signB;                   // B dominates
        end

        if (effSub && (aligned.sigA == aligned.sigB))
        begin
            sumNext.sign = 1'b0;                            // x - x gives +0
            sumNext.exactZero = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            sum <= '0;
        else if (en)
            sum <= sumNext;
    end

endmodule

//--- source/alignment.sv
// Inputs assumed normal, implicit one always prepended; exponent gaps above 26 collapse to sticky
`timescale 1ns/1ps

module alignment
    import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        en,
    input  logic        op,                                 // 0 add, 1 subtract
    input  fpOperand_t  opA,
    input  fpOperand_t  opB,
    output alignedOps_t aligned
);

    extSig_t     extA;                                      // A with implicit one and zero GRS
    extSig_t     extB;                                      // B with implicit one and zero GRS
    extSig_t     smallSig;                                  // Significand of the smaller operand
    extSig_t     shiftedSig;                                // Smaller significand after the shift
    exponent_t   expDiff;                                   // Distance between the exponents
    logic        aLarger;                                   // A has the larger or equal exponent
    logic [53:0] shiftWindow;                               // Shifted value over the lost bits
    logic        stickyBit;                                 // OR of bits pushed below round
    alignedOps_t alignedNext;

    always_comb
    begin
        extA = {1'b1, opA.fraction, 3'b000};                // Implicit one in front, GRS behind
        extB = {1'b1, opB.fraction, 3'b000};
        aLarger = (opA.exponent >= opB.exponent);           // Equal exponents keep A as reference

        if (aLarger)
        begin
            expDiff = opA.exponent - opB.exponent;
            smallSig = extB;                                // B gets shifted
        end
        else
        begin
            expDiff = opB.exponent - opA.exponent;
            smallSig = extA;                                // A gets shifted
        end

        shiftWindow = {smallSig, 27'd0} >> expDiff;         // Upper half kept, lower half lost

        if (expDiff > 8'd26)
        begin
            shiftedSig = '0;                                // Nothing left above sticky
            stickyBit = |smallSig;                          // Whole significand folds into sticky
        end
        else
        begin
            shiftedSig = shiftWindow[53:27];                // Significand, guard and round survive
            stickyBit = |shiftWindow[26:0];                 // Every bit shifted past the window
        end
        shiftedSig[0] = shiftedSig[0] | stickyBit;          // Merge into the sticky position

        alignedNext.signA = opA.sign;
        alignedNext.signB = opB.sign ^ op;                  // Subtract flips the sign of B
        alignedNext.exponent = aLarger ? opA.exponent : opB.exponent;
        alignedNext.sigA = aLarger ? extA : shiftedSig;
        alignedNext.sigB = aLarger ? shiftedSig : extB;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            aligned <= '0;
        else if (en)
            aligned <= alignedNext;                         // Captured on the start edge
    end

endmodule

//--- source/fpAddPkg.sv
// Binary32 only, normal operands with implicit one, round-to-nearest-even, no NaN or denormals
package fpAddPkg;

    typedef logic [7:0]         exponent_t;         // Biased exponent
    typedef logic [22:0]        fraction_t;         // Stored fraction without implicit one
    typedef logic [23:0]        significand_t;      // Fraction with implicit one
    typedef logic [26:0]        extSig_t;           // Significand followed by guard, round, sticky
    typedef logic signed [9:0]  wideExp_t;          // Signed exponent to expose under and overflow

    typedef struct packed
    {
        logic       sign;                           // Sign bit
        exponent_t  exponent;                       // Biased exponent
        fraction_t  fraction;                       // Stored fraction
    } fpOperand_t;

    typedef struct packed
    {
        logic       signA;                          // Effective sign of A
        logic       signB;                          // Effective sign of B, inverted on subtract
        exponent_t  exponent;                       // Larger of the two exponents
        extSig_t    sigA;                           // Aligned extended significand of A
        extSig_t    sigB;                           // Aligned extended significand of B
    } alignedOps_t;

    typedef struct packed
    {
        logic       sign;                           // Sign of the raw sum
        exponent_t  exponent;                       // Common exponent before normalization
        logic [27:0] magnitude;                     // Carry bit over the extended significand
        logic       exactZero;                      // Operands cancelled exactly
    } sumResult_t;

    typedef struct packed
    {
        logic         sign;                         // Result sign
        wideExp_t     exponent;                     // Adjusted exponent, may leave 1..254
        significand_t significand;                  // Normalized significand, MSB is the one
        logic         guard;                        // First bit below the LSB
        logic         round;                        // Second bit below the LSB
        logic         sticky;                       // OR of everything further down
        logic         isZero;                       // Cancellation result
    } normResult_t;

    typedef enum logic [2:0]
    {
        IDLE,                                       // Waiting for start
        ALIGN,                                      // Aligned operands held
        ADD,                                        // Sum register loads at end of cycle
        NORM,                                       // Normalized value loads at end of cycle
        ROUND                                       // Result registers load at end of cycle
    } addState_t;

endpackage
